//--- design/alu_lane.sv
`timescale 1ns/100ps

`include "kiwi_params.svh"

module alu_lane (
	input logic clk,
	input logic reset_i,
	input kiwi_pkg::issue_t issue_i,
	output kiwi_pkg::reg_idx_t rs1_idx_o,
	output kiwi_pkg::reg_idx_t rs2_idx_o,
	input kiwi_pkg::xlen_t rs1_val_i,
	input kiwi_pkg::xlen_t rs2_val_i,
	output kiwi_pkg::exe_result_t result_o
);

	import kiwi_pkg::*;

	issue_t issue_q;
	inst_u inst;
	logic [6:0] opcode;

	alu_op_e op;
	logic op_ok;
	reg_idx_t rd;
	reg_idx_t rs1_idx;
	reg_idx_t rs2_idx;
	xlen_t opa;
	xlen_t opb;
	logic [5:0] shamt;
	xlen_t alu_res;

	exe_result_t res_q;

	// issue register
	always_ff @(posedge clk) begin
		if (reset_i) begin
			issue_q.valid <= 1'b0;
		end else begin
			issue_q.valid <= issue_i.valid;
		end
		issue_q.inst <= issue_i.inst;
	end

	assign inst = issue_q.inst;
	assign opcode = inst.r.opcode;

	// decode through the view picked by the opcode
	always_comb begin
		op = ALU_ADD;
		op_ok = 1'b0;
		rd = '0;
		rs1_idx = '0;
		rs2_idx = '0;
		opb = '0;
		case (opcode)
			`OPC_OP: begin
				rd = inst.r.rd;
				rs1_idx = inst.r.rs1;
				rs2_idx = inst.r.rs2;
				opb = rs2_val_i;
				op_ok = 1'b1;
				case ({inst.r.funct7, inst.r.funct3})
					{7'b0000000, 3'b000}: op = ALU_ADD;
					{7'b0100000, 3'b000}: op = ALU_SUB;
					{7'b0000000, 3'b001}: op = ALU_SLL;
					{7'b0000000, 3'b010}: op = ALU_SLT;
					{7'b0000000, 3'b011}: op = ALU_SLTU;
					{7'b0000000, 3'b100}: op = ALU_XOR;
					{7'b0000000, 3'b101}: op = ALU_SRL;
					{7'b0100000, 3'b101}: op = ALU_SRA;
					{7'b0000000, 3'b110}: op = ALU_OR;
					{7'b0000000, 3'b111}: op = ALU_AND;
					default: op_ok = 1'b0;
				endcase
			end
			`OPC_OP_IMM: begin
				rd = inst.i.rd;
				rs1_idx = inst.i.rs1;
				opb = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
				op_ok = 1'b1;
				case (inst.i.funct3)
					3'b000: op = ALU_ADD;
					3'b001: op = ALU_SLL;
					3'b010: op = ALU_SLT;
					3'b011: op = ALU_SLTU;
					3'b100: op = ALU_XOR;
					// srai is told apart by bit 30
					3'b101: op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
					3'b110: op = ALU_OR;
					default: op = ALU_AND;
				endcase
			end
			`OPC_LUI: begin
				rd = inst.u.rd;
				opb = {{(`XLEN-32){inst.u.imm[19]}}, inst.u.imm, 12'b0};
				op = ALU_PASS_B;
				op_ok = 1'b1;
			end
			default: begin
				op_ok = 1'b0;
			end
		endcase
	end

	assign rs1_idx_o = rs1_idx;
	assign rs2_idx_o = rs2_idx;

	assign opa = rs1_val_i;
	assign shamt = opb[5:0];

	always_comb begin
		case (op)
			ALU_ADD: alu_res = opa + opb;
			ALU_SUB: alu_res = opa - opb;
			ALU_SLL: alu_res = opa << shamt;
			ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
			ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, opa < opb};
			ALU_XOR: alu_res = opa ^ opb;
			ALU_SRL: alu_res = opa >> shamt;
			ALU_SRA: alu_res = $signed(opa) >>> shamt;
			ALU_OR: alu_res = opa | opb;
			ALU_AND: alu_res = opa & opb;
			ALU_PASS_B: alu_res = opb;
			default: alu_res = '0;
		endcase
	end

	// result register
	always_ff @(posedge clk) begin
		if (reset_i) begin
			res_q.valid <= 1'b0;
		end else begin
			res_q.valid <= issue_q.valid & op_ok;
		end
		res_q.rd <= rd;
		res_q.value <= alu_res;
	end

	assign result_o = res_q;

endmodule

//--- design/kiwi_core.sv
`timescale 1ns/100ps

module kiwi_core (
	input logic clk,
	input logic reset_i,
	input kiwi_pkg::issue_t inst0_i,
	input kiwi_pkg::issue_t inst1_i,
	output kiwi_pkg::exe_result_t wb0_o,
	output kiwi_pkg::exe_result_t wb1_o
);

	import kiwi_pkg::*;

	reg_idx_t lane0_rs1_idx;
	reg_idx_t lane0_rs2_idx;
	reg_idx_t lane1_rs1_idx;
	reg_idx_t lane1_rs2_idx;
	xlen_t lane0_rs1_val;
	xlen_t lane0_rs2_val;
	xlen_t lane1_rs1_val;
	xlen_t lane1_rs2_val;
	exe_result_t lane0_res;
	exe_result_t lane1_res;

	alu_lane u_lane0 (
		.clk(clk),
		.reset_i(reset_i),
		.issue_i(inst0_i),
		.rs1_idx_o(lane0_rs1_idx),
		.rs2_idx_o(lane0_rs2_idx),
		.rs1_val_i(lane0_rs1_val),
		.rs2_val_i(lane0_rs2_val),
		.result_o(lane0_res)
	);

	alu_lane u_lane1 (
		.clk(clk),
		.reset_i(reset_i),
		.issue_i(inst1_i),
		.rs1_idx_o(lane1_rs1_idx),
		.rs2_idx_o(lane1_rs2_idx),
		.rs1_val_i(lane1_rs1_val),
		.rs2_val_i(lane1_rs2_val),
		.result_o(lane1_res)
	);

	// register file, forwarding and write-back
	regfile_wb u_regfile_wb (
		.clk(clk),
		.reset_i(reset_i),
		.lane0_rs1_idx_i(lane0_rs1_idx),
		.lane0_rs2_idx_i(lane0_rs2_idx),
		.lane1_rs1_idx_i(lane1_rs1_idx),
		.lane1_rs2_idx_i(lane1_rs2_idx),
		.lane0_rs1_val_o(lane0_rs1_val),
		.lane0_rs2_val_o(lane0_rs2_val),
		.lane1_rs1_val_o(lane1_rs1_val),
		.lane1_rs2_val_o(lane1_rs2_val),
		.lane0_res_i(lane0_res),
		.lane1_res_i(lane1_res),
		.wb0_o(wb0_o),
		.wb1_o(wb1_o)
	);

endmodule

//--- design/kiwi_params.svh
`ifndef KIWI_PARAMS_SVH
`define KIWI_PARAMS_SVH

// architectural widths
`define XLEN 64
`define ILEN 32

// integer register file
`define NUM_REGS 32
`define REG_IDX_W 5

// major opcodes handled by the integer lanes
`define OPC_OP 7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI 7'b0110111

`endif

//--- design/kiwi_pkg.sv
package kiwi_pkg;

`include "kiwi_params.svh"

	typedef logic [`XLEN-1:0] xlen_t;
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;

	// register-register format
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t rs2;
		reg_idx_t rs1;
		logic [2:0] funct3;
		reg_idx_t rd;
		logic [6:0] opcode;
	} r_view_t;

	// register-immediate format
	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t rs1;
		logic [2:0] funct3;
		reg_idx_t rd;
		logic [6:0] opcode;
	} i_view_t;

	// upper-immediate format
	typedef struct packed {
		logic [19:0] imm;
		reg_idx_t rd;
		logic [6:0] opcode;
	} u_view_t;

	// opcode field sits in the same place in every view
	typedef union packed {
		r_view_t r;
		i_view_t i;
		u_view_t u;
	} inst_u;

	typedef struct packed {
		logic valid;
		inst_u inst;
	} issue_t;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_SLL = 4'd2,
		ALU_SLT = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR = 4'd5,
		ALU_SRL = 4'd6,
		ALU_SRA = 4'd7,
		ALU_OR = 4'd8,
		ALU_AND = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_e;

	typedef struct packed {
		logic valid;
		reg_idx_t rd;
		xlen_t value;
	} exe_result_t;

endpackage

//--- design/regfile_wb.sv
`timescale 1ns/100ps

`include "kiwi_params.svh"

module regfile_wb (
	input logic clk,
	input logic reset_i,
	input kiwi_pkg::reg_idx_t lane0_rs1_idx_i,
	input kiwi_pkg::reg_idx_t lane0_rs2_idx_i,
	input kiwi_pkg::reg_idx_t lane1_rs1_idx_i,
	input kiwi_pkg::reg_idx_t lane1_rs2_idx_i,
	output kiwi_pkg::xlen_t lane0_rs1_val_o,
	output kiwi_pkg::xlen_t lane0_rs2_val_o,
	output kiwi_pkg::xlen_t lane1_rs1_val_o,
	output kiwi_pkg::xlen_t lane1_rs2_val_o,
	input kiwi_pkg::exe_result_t lane0_res_i,
	input kiwi_pkg::exe_result_t lane1_res_i,
	output kiwi_pkg::exe_result_t wb0_o,
	output kiwi_pkg::exe_result_t wb1_o
);

	import kiwi_pkg::*;

	xlen_t regs [`NUM_REGS];

	exe_result_t wb0_q;
	exe_result_t wb1_q;

	// x0 first, then the younger lane, then the array
	function automatic xlen_t fwd_read(
		input reg_idx_t idx,
		input xlen_t arr_val,
		input exe_result_t res0,
		input exe_result_t res1
	);
		xlen_t val;
		if (idx == '0) begin
			val = '0;
		end else if (res1.valid && res1.rd == idx) begin
			val = res1.value;
		end else if (res0.valid && res0.rd == idx) begin
			val = res0.value;
		end else begin
			val = arr_val;
		end
		return val;
	endfunction

	assign lane0_rs1_val_o = fwd_read(lane0_rs1_idx_i, regs[lane0_rs1_idx_i],
		lane0_res_i, lane1_res_i);
	assign lane0_rs2_val_o = fwd_read(lane0_rs2_idx_i, regs[lane0_rs2_idx_i],
		lane0_res_i, lane1_res_i);
	assign lane1_rs1_val_o = fwd_read(lane1_rs1_idx_i, regs[lane1_rs1_idx_i],
		lane0_res_i, lane1_res_i);
	assign lane1_rs2_val_o = fwd_read(lane1_rs2_idx_i, regs[lane1_rs2_idx_i],
		lane0_res_i, lane1_res_i);

	// lane 1 goes last so it wins a same-rd pair
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (lane0_res_i.valid && lane0_res_i.rd != '0) begin
				regs[lane0_res_i.rd] <= lane0_res_i.value;
			end
			if (lane1_res_i.valid && lane1_res_i.rd != '0) begin
				regs[lane1_res_i.rd] <= lane1_res_i.value;
			end
		end
	end

	// write-back stage
	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb0_q.valid <= 1'b0;
			wb1_q.valid <= 1'b0;
		end else begin
			wb0_q.valid <= lane0_res_i.valid;
			wb1_q.valid <= lane1_res_i.valid;
		end
		wb0_q.rd <= lane0_res_i.rd;
		wb0_q.value <= lane0_res_i.value;
		wb1_q.rd <= lane1_res_i.rd;
		wb1_q.value <= lane1_res_i.value;
	end

	assign wb0_o = wb0_q;
	assign wb1_o = wb1_q;

endmodule

//--- test/tb_kiwi_core.sv
`timescale 1ns/100ps

`include "kiwi_params.svh"

module tb_kiwi_core;

	import kiwi_pkg::*;

	typedef struct packed {
		exe_result_t r0;
		exe_result_t r1;
	} exp_pair_t;

	localparam issue_t NOP = '0;
	localparam int RESET_CYCLES = 5;
	localparam int FLUSH = 5;
	localparam int LEN_T1 = 10;
	localparam int LEN_T2 = 15;
	localparam int LEN_T3 = 10;
	localparam int LEN_T4 = 11;
	localparam int LEN_T5 = 8;
	localparam int LEN_T6 = 300;
	localparam int CYCLE_LIMIT = RESET_CYCLES + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5
		+ LEN_T6 + 6 * FLUSH + 50;

	logic clk;
	logic reset_i;
	issue_t inst0_i;
	issue_t inst1_i;
	exe_result_t wb0_o;
	exe_result_t wb1_o;

	xlen_t ref_regs [`NUM_REGS];
	exp_pair_t exp_q [$];
	exp_pair_t inflight [$];
	logic [31:0] lcg_state;
	int cycle_count = 0;
	int err_count = 0;
	int check_count = 0;
	int test_count = 0;
	int test_err_base = 0;

	kiwi_core i_dut (
		.clk(clk),
		.reset_i(reset_i),
		.inst0_i(inst0_i),
		.inst1_i(inst1_i),
		.wb0_o(wb0_o),
		.wb1_o(wb1_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic issue_t r_op(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
		reg_idx_t rs1, reg_idx_t rs2);
		issue_t x;
		x.valid = 1'b1;
		x.inst = {f7, rs2, rs1, f3, rd, `OPC_OP};
		return x;
	endfunction

	function automatic issue_t i_op(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
		logic [11:0] imm);
		issue_t x;
		x.valid = 1'b1;
		x.inst = {imm, rs1, f3, rd, `OPC_OP_IMM};
		return x;
	endfunction

	function automatic issue_t u_lui(reg_idx_t rd, logic [19:0] imm);
		issue_t x;
		x.valid = 1'b1;
		x.inst = {imm, rd, `OPC_LUI};
		return x;
	endfunction

	function automatic xlen_t alu_model(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
		xlen_t v;
		case (f3)
			3'd0: v = alt ? a - b : a + b;
			3'd1: v = a << b[5:0];
			3'd2: v = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			3'd3: v = (a < b) ? 64'd1 : 64'd0;
			3'd4: v = a ^ b;
			3'd5: begin
				if (alt) begin
					v = $signed(a) >>> b[5:0];
				end else begin
					v = a >> b[5:0];
				end
			end
			3'd6: v = a | b;
			default: v = a & b;
		endcase
		return v;
	endfunction

	// one instruction against the register state before its pair
	function automatic exe_result_t exec_one(issue_t is);
		exe_result_t r;
		logic [31:0] w;
		logic [6:0] f7;
		logic [2:0] f3;
		logic ok;
		xlen_t a;
		w = is.inst;
		f7 = w[31:25];
		f3 = w[14:12];
		a = ref_regs[w[19:15]];
		r = '0;
		r.rd = w[11:7];
		ok = 1'b0;
		case (w[6:0])
			`OPC_OP: begin
				ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				r.value = alu_model(f3, f7[5], a, ref_regs[w[24:20]]);
			end
			`OPC_OP_IMM: begin
				ok = 1'b1;
				r.value = alu_model(f3, f3 == 3'd5 && w[30], a,
					{{(`XLEN-12){w[31]}}, w[31:20]});
			end
			`OPC_LUI: begin
				ok = 1'b1;
				r.value = {{(`XLEN-32){w[31]}}, w[31:12], 12'h000};
			end
			default: ok = 1'b0;
		endcase
		r.valid = is.valid && ok;
		return r;
	endfunction

	function automatic exp_pair_t ref_exec(issue_t a, issue_t b);
		exp_pair_t e;
		e.r0 = exec_one(a);
		e.r1 = exec_one(b);
		if (e.r0.valid && e.r0.rd != 0) begin
			ref_regs[e.r0.rd] = e.r0.value;
		end
		if (e.r1.valid && e.r1.rd != 0) begin
			ref_regs[e.r1.rd] = e.r1.value;
		end
		return e;
	endfunction

	// k picks one of 10 R ops, 9 I ops or LUI over x0..x7
	function automatic issue_t rand_inst();
		logic [31:0] r;
		logic [31:0] s;
		int k;
		logic [2:0] f3;
		logic [11:0] imm;
		issue_t x;
		r = lcg_next();
		s = lcg_next();
		k = s[31:16] % 20;
		imm = s[11:0];
		if (k < 10) begin
			f3 = k - (k >= 1) - (k >= 7);
			x = r_op((k == 1 || k == 7) ? 7'h20 : 7'h00, f3, {2'b00, r[18:16]},
				{2'b00, r[21:19]}, {2'b00, r[24:22]});
		end else if (k < 19) begin
			f3 = (k - 10) - (k >= 16);
			if (f3 == 3'd1 || f3 == 3'd5) begin
				imm = {(k == 16) ? 6'b010000 : 6'b000000, s[5:0]};
			end
			x = i_op(f3, {2'b00, r[18:16]}, {2'b00, r[21:19]}, imm);
		end else begin
			x = u_lui({2'b00, r[18:16]}, {s[15:0], r[31:28]});
		end
		return x;
	endfunction

	task automatic check_result(input string name, input exe_result_t exp,
		input exe_result_t got);
		check_count++;
		if (got.valid !== exp.valid) begin
			if (exp.valid) begin
				$display("%s gave no valid result where one for x%0d was due", name, exp.rd);
			end else begin
				$display("%s gave a valid result for x%0d where none was due", name, got.rd);
			end
			err_count++;
		end else if (exp.valid && (got.rd !== exp.rd || got.value !== exp.value)) begin
			$display("Error %s expected rd %h value %h got rd %h value %h",
				name, exp.rd, exp.value, got.rd, got.value);
			err_count++;
		end
	endtask

	task automatic issue_pair(input issue_t a, input issue_t b);
		@(negedge clk);
		inst0_i = a;
		inst1_i = b;
		exp_q.push_back(ref_exec(a, b));
	endtask

	task automatic end_test(input int num, input string name);
		repeat (FLUSH - 1) issue_pair(NOP, NOP);
		@(posedge clk);
		$display("test %0d %s: %0d errors", num, name, err_count - test_err_base);
		test_err_base = err_count;
		test_count++;
	endtask

	// pairs sampled at edge k show on wb after edge k+2
	initial begin
		exp_pair_t e;
		inflight.push_back('0);
		inflight.push_back('0);
		wait (reset_i == 1'b0);
		forever begin
			@(posedge clk);
			if (exp_q.size() > 0) begin
				inflight.push_back(exp_q.pop_front());
			end else begin
				inflight.push_back('0);
			end
			@(negedge clk);
			e = inflight.pop_front();
			check_result("wb0_o", e.r0, wb0_o);
			check_result("wb1_o", e.r1, wb1_o);
		end
	end

	task automatic idle_after_reset();
		repeat (LEN_T1 - 2) issue_pair(NOP, NOP);
		issue_pair(r_op(0, 0, 1, 2, 3), r_op(0, 6, 6, 7, 8));
		issue_pair(i_op(0, 9, 10, 12'h000), r_op(0, 3, 11, 0, 12));
	endtask

	task automatic r_type_ops();
		// x1=-1 x2=0xffffffff80000000 x3=1 x4=63 x5=0x7ffff7ff x6=-2048 x7=min
		issue_pair(i_op(0, 1, 0, 12'hfff), u_lui(2, 20'h80000));
		issue_pair(i_op(0, 3, 0, 12'h001), i_op(0, 4, 0, 12'h03f));
		issue_pair(u_lui(5, 20'h7ffff), i_op(0, 6, 0, 12'h800));
		issue_pair(i_op(0, 5, 5, 12'h7ff), i_op(1, 7, 1, 12'h03f));
		issue_pair(r_op(0, 0, 8, 1, 3), r_op(7'h20, 0, 9, 3, 1));
		issue_pair(r_op(0, 1, 10, 3, 4), r_op(0, 2, 11, 7, 3));
		issue_pair(r_op(0, 3, 12, 7, 3), r_op(0, 4, 13, 1, 5));
		issue_pair(r_op(0, 5, 14, 7, 4), r_op(7'h20, 5, 15, 7, 4));
		issue_pair(r_op(0, 6, 16, 2, 5), r_op(0, 7, 17, 1, 6));
		issue_pair(r_op(7'h20, 0, 18, 1, 3), r_op(0, 0, 19, 7, 1));
		issue_pair(r_op(0, 2, 20, 1, 3), r_op(0, 1, 21, 1, 4));
		issue_pair(r_op(0, 4, 22, 2, 7), r_op(0, 3, 23, 3, 1));
		issue_pair(r_op(7'h20, 5, 24, 2, 3), r_op(0, 5, 25, 2, 3));
		issue_pair(r_op(0, 7, 26, 5, 6), r_op(0, 6, 27, 7, 3));
		issue_pair(r_op(7'h20, 5, 28, 7, 1), r_op(0, 5, 29, 7, 1));
	endtask

	task automatic i_type_ops();
		issue_t bad;
		issue_t off;
		bad = i_op(0, 8, 1, 12'h010);
		bad.inst.i.opcode = 7'b0000011;
		off = i_op(0, 10, 0, 12'h005);
		off.valid = 1'b0;
		issue_pair(i_op(0, 8, 1, 12'hfff), i_op(2, 9, 7, 12'hfff));
		issue_pair(i_op(3, 10, 3, 12'hfff), i_op(4, 11, 1, 12'h555));
		issue_pair(i_op(6, 12, 2, 12'h800), i_op(7, 13, 5, 12'h0f0));
		issue_pair(i_op(1, 14, 3, 12'h000), i_op(1, 15, 3, 12'h03f));
		issue_pair(i_op(5, 16, 7, 12'h000), i_op(5, 17, 7, 12'h03f));
		issue_pair(i_op(5, 18, 7, 12'h400), i_op(5, 19, 7, 12'h43f));
		issue_pair(u_lui(20, 20'hfffff), u_lui(21, 20'h12345));
		// none of the next four words may write a register
		issue_pair(bad, r_op(7'h01, 0, 9, 1, 3));
		issue_pair(off, r_op(7'h20, 1, 11, 1, 3));
		issue_pair(r_op(0, 0, 22, 8, 10), r_op(0, 0, 23, 9, 11));
	endtask

	task automatic forward_chain();
		issue_pair(i_op(0, 1, 0, 12'h005), i_op(0, 2, 0, 12'h007));
		repeat (LEN_T4 - 1) issue_pair(r_op(0, 0, 1, 1, 2), r_op(7'h20, 0, 2, 1, 2));
	endtask

	task automatic pair_ordering();
		issue_pair(i_op(0, 3, 0, 12'h064), i_op(0, 4, 0, 12'h0c8));
		issue_pair(i_op(0, 3, 0, 12'h00b), r_op(0, 0, 5, 3, 0));
		issue_pair(i_op(0, 6, 0, 12'h001), i_op(0, 6, 0, 12'h002));
		issue_pair(r_op(0, 0, 7, 6, 0), r_op(0, 0, 8, 6, 6));
		issue_pair(i_op(0, 0, 3, 12'h005), u_lui(0, 20'h12345));
		issue_pair(r_op(0, 0, 9, 0, 0), r_op(0, 6, 10, 0, 3));
		issue_pair(NOP, NOP);
		issue_pair(r_op(0, 0, 11, 6, 0), r_op(0, 0, 12, 0, 0));
	endtask

	initial begin
		inst0_i = NOP;
		inst1_i = NOP;
		reset_i = 1'b1;
		lcg_state = 32'd22341;
		for (int i = 0; i < `NUM_REGS; i++) begin
			ref_regs[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;
		idle_after_reset();
		end_test(1, "idle after reset");
		r_type_ops();
		end_test(2, "register-register ops");
		i_type_ops();
		end_test(3, "immediate ops and lui");
		forward_chain();
		end_test(4, "forwarding chain");
		pair_ordering();
		end_test(5, "pair ordering and x0");
		repeat (LEN_T6) issue_pair(rand_inst(), rand_inst());
		end_test(6, "random pairs");
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+design
design/kiwi_pkg.sv
design/alu_lane.sv
design/regfile_wb.sv
design/kiwi_core.sv
test/tb_kiwi_core.sv
